//--- all.f
hw/bpu_pkg.sv
hw/bpu_update_if.sv
hw/bpu_btb.sv
hw/bpu_dir.sv
hw/bpu_ras.sv
hw/bpu_pc_ctrl.sv
hw/bpu_top.sv
dv/tb_clk_gen.sv
dv/tb_bpu_top.sv

//--- dv/bpu_cases.txt
# C pc mask taken next_pc | F addr | I cycles (all hex)
# U upd_mask pc0 pc1 target br_type taken type_miss target_miss history scnt
# reset pc, sequential advance with stalls
C 1c000000 3 0 1c000008
C 1c000008 3 0 1c000010
I 4
# odd-word flush, slot 0 dead
F 1c000104
C 1c000104 2 0 1c000108
# jump in slot 0 with target miss
U 1 1c000200 0 1c000400 1 1 0 1 0 0
F 1c000200
C 1c000200 1 1 1c000400
C 1c000400 3 0 1c000408
# conditional in slot 1, enter then train
U 1 1c000804 0 1c000900 0 0 1 0 0 0
F 1c000800
C 1c000800 3 0 1c000808
# history 0 -> 1, counter written at index 00, lookup reads index 10
U 1 1c000804 0 1c000900 0 1 0 0 0 1
F 1c000800
C 1c000800 3 0 1c000808
# history f -> f, next_scnt(01,1) = 10 at index f0
U 1 1c000804 0 1c000900 0 1 0 0 f 1
F 1c000800
C 1c000800 3 2 1c000900
# return entry, then calls at 1c001000 and 1c003000
U 1 1c002004 0 0 3 1 1 0 0 0
U 1 1c001000 0 1c005000 2 1 1 1 0 0
F 1c002000
C 1c002000 3 2 1c001004
U 1 1c003000 0 1c005000 2 1 1 1 0 0
F 1c002000
C 1c002000 3 2 1c003004
U 1 1c002004 0 0 3 1 0 0 0 0
F 1c002000
C 1c002000 3 2 1c001004
# two corrections at once, slot 0 only
U 3 1c004000 1c004104 1c006000 1 1 0 1 0 0
F 1c004100
C 1c004100 3 0 1c004108
F 1c004000
C 1c004000 1 1 1c006000

//--- dv/tb_bpu_top.sv
// bpu testbench; reads dv/bpu_cases.txt from the project root, stops at the first error
`default_nettype none

module tb_bpu_top;
    timeunit 1ns;
    timeprecision 100ps;
    import bpu_pkg::*;

    localparam int    TIMEOUT_CYCLES = 50;
    localparam int    DRIVE_DELAY    = 1;  // inputs change 1 ns after the edge
    localparam int    SAMPLE_DELAY   = 2;  // outputs read well inside the cycle
    localparam string CASE_FILE      = "dv/bpu_cases.txt";

    logic                             clk;
    logic                             rst_n;
    logic                             flush;
    logic [31:0]                      redir_addr;
    logic [1:0]                       corr_update;
    logic [1:0][31:0]                 corr_pc;
    logic [1:0][31:0]                 corr_target;
    br_type_e [1:0]                   corr_br_type;
    logic [1:0]                       corr_taken;
    logic [1:0]                       corr_type_miss;
    logic [1:0]                       corr_target_miss;
    logic [1:0][BPU_HISTORY_LEN-1:0]  corr_history;
    logic [1:0][1:0]                  corr_scnt;
    logic                             fetch_ready;
    logic                             fetch_valid;
    logic [31:0]                      fetch_pc;
    logic [1:0]                       fetch_mask;
    logic [1:0]                       pred_taken;
    logic [31:0]                      pred_next_pc;
    logic [1:0][BPU_HISTORY_LEN-1:0]  pred_history;
    logic [1:0][1:0]                  pred_scnt;
    logic [31:0]                      lfsr_state;   // back-pressure source

    // expected bht and pht contents, per bank
    logic [BPU_HISTORY_LEN-1:0]       hist_model [2][BPU_BTB_DEPTH];
    logic [1:0]                       cnt_model  [2][BPU_PHT_DEPTH];

    tb_clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    bpu_top i_bpu_top (
        .clk, .rst_n,
        .flush_i            (flush),
        .redir_addr_i       (redir_addr),
        .corr_update_i      (corr_update),
        .corr_pc_i          (corr_pc),
        .corr_target_i      (corr_target),
        .corr_br_type_i     (corr_br_type),
        .corr_taken_i       (corr_taken),
        .corr_type_miss_i   (corr_type_miss),
        .corr_target_miss_i (corr_target_miss),
        .corr_history_i     (corr_history),
        .corr_scnt_i        (corr_scnt),
        .fetch_ready_i      (fetch_ready),
        .fetch_valid_o      (fetch_valid),
        .fetch_pc_o         (fetch_pc),
        .fetch_mask_o       (fetch_mask),
        .pred_taken_o       (pred_taken),
        .pred_next_pc_o     (pred_next_pc),
        .pred_history_o     (pred_history),
        .pred_scnt_o        (pred_scnt)
    );

    // right-shift galois lfsr, x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // pc[14:9] folded onto pc[8:3]
    function automatic int fold_index(input logic [31:0] pc);
        return int'(((pc >> 9) ^ (pc >> 3)) & 32'h3f);
    endfunction

    // history above the four pc bits 6:3
    function automatic int counter_index(input logic [BPU_HISTORY_LEN-1:0] history,
                                         input logic [31:0] pc);
        return int'(history) * 16 + int'((pc >> 3) & 32'hf);
    endfunction

    // saturating, one step up or down
    function automatic logic [1:0] step_counter(input logic [1:0] scnt, input logic taken);
        if (taken) begin
            return (scnt == 2'b11) ? scnt : scnt + 2'd1;
        end
        return (scnt == 2'b00) ? scnt : scnt - 2'd1;
    endfunction

    // two lfsr bits give 0..3 stall cycles
    task automatic draw_stalls(output int count);
        count = 0;
        repeat (2) begin
            count      = (count << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
        end
    endtask

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_fields(input int got, input int want, input string kind);
        if (got != want) begin
            $display("case file line of kind %s has %0d fields, needs %0d", kind, got, want);
            fail_run();
        end
    endtask

    // expected tables after one applied correction
    task automatic train_model(input logic [31:0] pc, input logic taken, input logic type_miss,
                               input logic [BPU_HISTORY_LEN-1:0] history,
                               input logic [1:0] scnt);
        int bank;
        bank = int'(pc[2]);
        hist_model[bank][fold_index(pc)] = type_miss ? BPU_HISTORY_LEN'(taken)
                                                     : BPU_HISTORY_LEN'({history, taken});
        cnt_model[bank][counter_index(history, pc)] = step_counter(scnt, taken);
    endtask

    // stall a few cycles, then compare the offered pair at the transfer
    task automatic run_check(input logic [31:0] exp_pc, input logic [1:0] exp_mask,
                             input logic [1:0] exp_taken, input logic [31:0] exp_next);
        int                         stalls;
        int                         waited;
        logic [31:0]                hold_pc;
        logic [BPU_HISTORY_LEN-1:0] exp_hist;
        logic [1:0]                 exp_cnt;
        draw_stalls(stalls);
        fetch_ready = 1'b0;
        hold_pc     = fetch_pc;
        repeat (stalls) begin
            next_cycle();
            check_hex("fetch_pc_o", fetch_pc, hold_pc); // no move while stalled
        end
        fetch_ready = 1'b1;
        waited      = 0;
        while (fetch_valid !== 1'b1) begin
            if (waited == TIMEOUT_CYCLES) begin
                $display("timeout: fetch_valid_o stayed low for %0d cycles", TIMEOUT_CYCLES);
                fail_run();
            end
            next_cycle();
            waited++;
        end
        #SAMPLE_DELAY;
        check_hex("fetch_pc_o", fetch_pc, exp_pc);
        check_hex("fetch_mask_o", 32'(fetch_mask), 32'(exp_mask));
        check_hex("pred_taken_o", 32'(pred_taken), 32'(exp_taken));
        check_hex("pred_next_pc_o", pred_next_pc, exp_next);
        for (int s = 0; s < 2; s++) begin
            exp_hist = hist_model[s][fold_index(exp_pc)];
            exp_cnt  = cnt_model[s][counter_index(exp_hist, exp_pc)];
            check_hex("pred_history_o", 32'(pred_history[s]), 32'(exp_hist));
            check_hex("pred_scnt_o", 32'(pred_scnt[s]), 32'(exp_cnt));
        end
        next_cycle(); // transfer edge
        fetch_ready = 1'b0;
    endtask

    // ready high on purpose, flush must still win
    task automatic run_flush(input logic [31:0] addr);
        fetch_ready = 1'b1;
        flush       = 1'b1;
        redir_addr  = addr;
        next_cycle();
        check_hex("fetch_pc_o", fetch_pc, addr);
        flush       = 1'b0;
        fetch_ready = 1'b0;
    endtask

    // one-cycle correction, both slots share all fields but pc
    task automatic run_correction(input logic [1:0] mask, input logic [31:0] pc0,
                                  input logic [31:0] pc1, input logic [31:0] target,
                                  input logic [1:0] br_type, input logic taken,
                                  input logic type_miss, input logic target_miss,
                                  input logic [BPU_HISTORY_LEN-1:0] history,
                                  input logic [1:0] scnt);
        corr_pc[0] = pc0;
        corr_pc[1] = pc1;
        for (int s = 0; s < 2; s++) begin
            corr_target[s]      = target;
            corr_br_type[s]     = br_type_e'(br_type);
            corr_taken[s]       = taken;
            corr_type_miss[s]   = type_miss;
            corr_target_miss[s] = target_miss;
            corr_history[s]     = history;
            corr_scnt[s]        = scnt;
        end
        corr_update = mask;
        if (mask != 2'b00) begin
            train_model(mask[0] ? pc0 : pc1, taken, type_miss, history, scnt); // slot 0 first
        end
        next_cycle(); // tables take it here
        corr_update = 2'b00;
    endtask

    initial begin
        int                         fd;
        int                         n;
        int                         waited;
        string                      kind;
        string                      line;
        logic [31:0]                pc0;
        logic [31:0]                pc1;
        logic [31:0]                target;
        logic [31:0]                cycles;
        logic [1:0]                 mask;
        logic [1:0]                 taken;
        logic [1:0]                 br_type;
        logic [1:0]                 scnt;
        logic                       tk;
        logic                       type_miss;
        logic                       target_miss;
        logic [BPU_HISTORY_LEN-1:0] history;

        lfsr_state       = 32'h40e9;
        flush            = 1'b0;
        redir_addr       = '0;
        corr_update      = '0;
        corr_pc          = '0;
        corr_target      = '0;
        corr_br_type[0]  = BR_NORMAL;
        corr_br_type[1]  = BR_NORMAL;
        corr_taken       = '0;
        corr_type_miss   = '0;
        corr_target_miss = '0;
        corr_history     = '0;
        corr_scnt        = '0;
        fetch_ready      = 1'b0;

        // tables start cleared
        for (int b = 0; b < 2; b++) begin
            for (int e = 0; e < BPU_BTB_DEPTH; e++) begin
                hist_model[b][e] = '0;
            end
            for (int e = 0; e < BPU_PHT_DEPTH; e++) begin
                cnt_model[b][e] = 2'b00;
            end
        end

        next_cycle();
        assert (fetch_valid === 1'b0) else begin
            $display("fetch_valid_o is high while rst_n is low");
            fail_run();
        end
        waited = 0;
        while (rst_n !== 1'b1) begin
            if (waited == TIMEOUT_CYCLES) begin
                $display("timeout: rst_n never released");
                fail_run();
            end
            @(posedge clk); // rst_n is stable at the edge
            waited++;
        end
        #DRIVE_DELAY;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open case file %s", CASE_FILE);
            fail_run();
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                n = $fgets(line, fd); // rest of a note line
            end else if (kind == "C") begin
                n = $fscanf(fd, "%h %h %h %h", pc0, mask, taken, target);
                check_fields(n, 4, kind);
                run_check(pc0, mask, taken, target);
            end else if (kind == "U") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", mask, pc0, pc1, target,
                            br_type, tk, type_miss, target_miss, history, scnt);
                check_fields(n, 10, kind);
                run_correction(mask, pc0, pc1, target, br_type, tk, type_miss,
                               target_miss, history, scnt);
            end else if (kind == "F") begin
                n = $fscanf(fd, "%h", pc0);
                check_fields(n, 1, kind);
                run_flush(pc0);
            end else if (kind == "I") begin
                n = $fscanf(fd, "%h", cycles);
                check_fields(n, 1, kind);
                repeat (cycles) next_cycle();
            end else begin
                $display("unknown line kind %s in case file", kind);
                fail_run();
            end
        end
        $fclose(fd);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
// testbench clock and reset source; 8 ns period, rst_n low for 16 rising edges, then released 1 ns after
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 4;  // 8 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

    // synchronous reset, released just after an edge like any other input
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- hw/bpu_btb.sv
// two-bank btb, bank = pc[2]; only valid bits reset, tags and targets stay unknown until written
`default_nettype none

module bpu_btb (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  [31:0]                   lookup_pc_i,
    bpu_update_if.tbl                     upd,
    output logic [1:0]                    hit_o,
    output bpu_pkg::br_type_e [1:0]       br_type_o,
    output logic [1:0][31:0]              target_o
);
    import bpu_pkg::*;

    btb_entry_t               btb_q [2][BPU_BTB_DEPTH]; // [bank][index]
    btb_entry_t               rd_entry [2];
    logic [BPU_BTB_LEN-1:0]   rd_idx;
    logic [BPU_TAG_LEN-1:0]   rd_tag;
    logic [BPU_BTB_LEN-1:0]   wr_idx;
    logic                     wr_en;
    btb_entry_t               wr_entry;

    // lookup, both banks share one index
    assign rd_idx = btb_index(lookup_pc_i);
    assign rd_tag = btb_tag(lookup_pc_i);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rd_entry[i]  = btb_q[i][rd_idx];
            hit_o[i]     = rd_entry[i].valid && (rd_entry[i].tag == rd_tag);
            br_type_o[i] = rd_entry[i].br_type;
            target_o[i]  = rd_entry[i].target_pc;
        end
    end

    // write only when the backend saw a type or target miss
    assign wr_en  = upd.update && (upd.type_miss || upd.target_miss);
    assign wr_idx = btb_index(upd.pc);

    always_comb begin
        wr_entry.valid     = 1'b1; // every correction here is a branch
        wr_entry.tag       = btb_tag(upd.pc);
        wr_entry.br_type   = upd.br_type;
        wr_entry.target_pc = upd.target_pc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < BPU_BTB_DEPTH; e++) begin
                    btb_q[b][e].valid <= 1'b0; // empty table
                end
            end
        end else if (wr_en) begin
            btb_q[upd.pc[2]][wr_idx] <= wr_entry; // bank by slot
        end
    end

endmodule

`default_nettype wire

//--- hw/bpu_dir.sv
// local history plus two-bit counters per bank; both tables clear on reset, trained by backend only
`default_nettype none

module bpu_dir (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire  [31:0]                                  lookup_pc_i,
    bpu_update_if.tbl                                    upd,
    output logic [1:0]                                   taken_o,
    output logic [1:0][bpu_pkg::BPU_HISTORY_LEN-1:0]     history_o,
    output logic [1:0][1:0]                              scnt_o
);
    import bpu_pkg::*;

    logic [BPU_HISTORY_LEN-1:0] bht_q [2][BPU_BTB_DEPTH]; // per-branch history
    logic [1:0]                 pht_q [2][BPU_PHT_DEPTH]; // saturating counters
    logic [BPU_BTB_LEN-1:0]     bht_rd_idx;
    logic [BPU_BTB_LEN-1:0]     bht_wr_idx;
    logic [BPU_HISTORY_LEN+BPU_PHT_PC_LEN-1:0] pht_wr_idx;
    logic [BPU_HISTORY_LEN-1:0] hist_next;
    logic                       bank;

    assign bht_rd_idx = btb_index(lookup_pc_i); // same fold as the btb

    // each bank's history picks its own counter
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            history_o[i] = bht_q[i][bht_rd_idx];
            scnt_o[i]    = pht_q[i][pht_index(history_o[i], lookup_pc_i)];
            taken_o[i]   = scnt_o[i][1]; // upper bit is the direction
        end
    end

    // training from the selected correction
    assign bank       = upd.pc[2];
    assign bht_wr_idx = btb_index(upd.pc);
    assign pht_wr_idx = pht_index(upd.history, upd.pc); // history the backend returned

    // new entry starts its history from this outcome
    assign hist_next = upd.type_miss ? {{(BPU_HISTORY_LEN-1){1'b0}}, upd.taken}
                                     : {upd.history[BPU_HISTORY_LEN-2:0], upd.taken};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                for (int e = 0; e < BPU_BTB_DEPTH; e++) begin
                    bht_q[b][e] <= '0;
                end
                for (int e = 0; e < BPU_PHT_DEPTH; e++) begin
                    pht_q[b][e] <= 2'b00; // strongly not taken
                end
            end
        end else if (upd.update) begin
            bht_q[bank][bht_wr_idx] <= hist_next;
            pht_q[bank][pht_wr_idx] <= next_scnt(upd.scnt, upd.taken);
        end
    end

endmodule

`default_nettype wire

//--- hw/bpu_pc_ctrl.sv
// fetch pc, correction select and next-pc choice; lookup is single-cycle, flush beats a transfer
`default_nettype none

module bpu_pc_ctrl (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire                                          flush_i,
    input  wire  [31:0]                                  redir_addr_i,
    // backend corrections, two slots
    input  wire  [1:0]                                   corr_update_i,
    input  wire  [1:0][31:0]                             corr_pc_i,
    input  wire  [1:0][31:0]                             corr_target_i,
    input  wire  bpu_pkg::br_type_e [1:0]                corr_br_type_i,
    input  wire  [1:0]                                   corr_taken_i,
    input  wire  [1:0]                                   corr_type_miss_i,
    input  wire  [1:0]                                   corr_target_miss_i,
    input  wire  [1:0][bpu_pkg::BPU_HISTORY_LEN-1:0]     corr_history_i,
    input  wire  [1:0][1:0]                              corr_scnt_i,
    bpu_update_if.ctrl                                   upd,
    // table lookup results
    input  wire  [1:0]                                   btb_hit_i,
    input  wire  bpu_pkg::br_type_e [1:0]                btb_type_i,
    input  wire  [1:0][31:0]                             btb_target_i,
    input  wire  [1:0]                                   dir_taken_i,
    input  wire  [31:0]                                  ras_top_i,
    output logic [31:0]                                  lookup_pc_o,
    // fetch stream
    input  wire                                          fetch_ready_i,
    output logic                                         fetch_valid_o,
    output logic [31:0]                                  fetch_pc_o,
    output logic [1:0]                                   fetch_mask_o,
    output logic [1:0]                                   pred_taken_o,
    output logic [31:0]                                  pred_next_pc_o
);
    import bpu_pkg::*;

    logic [31:0]      pc_q;
    logic             valid_q;
    logic             sel;          // chosen correction slot
    logic [1:0]       slot_taken;
    logic [1:0][31:0] slot_target;
    logic             slot0_live;
    logic [31:0]      seq_pc;       // next aligned pair
    logic [31:0]      next_pc;

    // first slot marked for update wins
    assign sel = !corr_update_i[0];

    assign upd.update      = corr_update_i[sel];
    assign upd.pc          = corr_pc_i[sel];
    assign upd.target_pc   = corr_target_i[sel];
    assign upd.br_type     = corr_br_type_i[sel];
    assign upd.taken       = corr_taken_i[sel];
    assign upd.type_miss   = corr_type_miss_i[sel];
    assign upd.target_miss = corr_target_miss_i[sel];
    assign upd.history     = corr_history_i[sel];
    assign upd.scnt        = corr_scnt_i[sel];

    // per-slot prediction
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // unconditional types ignore the counter
            slot_taken[i]  = btb_hit_i[i] && ((btb_type_i[i] != BR_NORMAL) || dir_taken_i[i]);
            slot_target[i] = (btb_type_i[i] == BR_RET) ? ras_top_i : btb_target_i[i];
        end
    end

    assign slot0_live = !pc_q[2]; // odd-word pc skips slot 0
    assign seq_pc     = {pc_q[31:3] + 29'd1, 3'b000};

    always_comb begin
        next_pc = seq_pc;
        if (slot0_live && slot_taken[0]) begin
            next_pc = slot_target[0];
        end else if (slot_taken[1]) begin
            next_pc = slot_target[1];
        end
    end

    // pc register, flush first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= BPU_INIT_PC;
        end else if (flush_i) begin
            pc_q <= redir_addr_i;
        end else if (valid_q && fetch_ready_i) begin
            pc_q <= next_pc; // advance on transfer
        end
    end

    // valid from the first cycle after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    assign lookup_pc_o    = pc_q;
    assign fetch_valid_o  = valid_q;
    assign fetch_pc_o     = pc_q;
    assign fetch_mask_o   = {!(slot0_live && slot_taken[0]), slot0_live};
    assign pred_taken_o   = slot_taken;
    assign pred_next_pc_o = next_pc;

endmodule

`default_nettype wire

//--- hw/bpu_pkg.sv
// shared geometry, types and index helpers; btb_index assumes BPU_BTB_LEN of 6 and pc[19:12] tags
`default_nettype none

package bpu_pkg;

    localparam logic [31:0] BPU_INIT_PC = 32'h1c000000; // reset fetch pc
    localparam int BPU_BTB_LEN     = 6;   // btb and bht index width
    localparam int BPU_BTB_DEPTH   = 64;  // entries per bank
    localparam int BPU_TAG_LEN     = 8;   // pc[19:12]
    localparam int BPU_HISTORY_LEN = 4;   // local history bits
    localparam int BPU_PHT_PC_LEN  = 4;   // pc[6:3] part of pht index
    localparam int BPU_PHT_DEPTH   = 256; // counters per bank
    localparam int BPU_RAS_DEPTH   = 8;
    localparam int BPU_RAS_LEN     = 3;   // ras pointer width

    typedef enum logic [1:0] {
        BR_NORMAL = 2'b00, // conditional branch
        BR_JUMP   = 2'b01,
        BR_CALL   = 2'b10,
        BR_RET    = 2'b11
    } br_type_e;

    typedef struct packed {
        logic                   valid;
        logic [BPU_TAG_LEN-1:0] tag;
        br_type_e               br_type;
        logic [31:0]            target_pc;
    } btb_entry_t; // 43 bits

    // xor fold of two 6-bit pc slices
    function automatic logic [BPU_BTB_LEN-1:0] btb_index(input logic [31:0] pc);
        return pc[14:9] ^ pc[8:3];
    endfunction

    function automatic logic [BPU_TAG_LEN-1:0] btb_tag(input logic [31:0] pc);
        return pc[BPU_TAG_LEN+11:12];
    endfunction

    // history in the upper bits, pc bits below
    function automatic logic [BPU_HISTORY_LEN+BPU_PHT_PC_LEN-1:0] pht_index(
        input logic [BPU_HISTORY_LEN-1:0] history,
        input logic [31:0]                pc
    );
        return {history, pc[BPU_PHT_PC_LEN+2:3]};
    endfunction

    // two-bit saturating step, weak states cross over on one miss
    function automatic logic [1:0] next_scnt(input logic [1:0] scnt, input logic taken);
        case (scnt)
            2'b00:   return taken ? 2'b01 : 2'b00; // strong not taken
            2'b01:   return taken ? 2'b10 : 2'b00; // weak not taken
            2'b10:   return taken ? 2'b11 : 2'b01; // weak taken
            default: return taken ? 2'b11 : 2'b10; // strong taken
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/bpu_ras.sv
// eight-entry return stack driven by backend call/ret corrections; overflow and underflow wrap silently
`default_nettype none

module bpu_ras (
    input  wire          clk,
    input  wire          rst_n,
    bpu_update_if.tbl    upd,
    output logic [31:0]  top_o
);
    import bpu_pkg::*;

    logic [31:0]            stack_q [BPU_RAS_DEPTH]; // return addresses
    logic [BPU_RAS_LEN-1:0] top_q;  // points at the newest entry
    logic [BPU_RAS_LEN-1:0] wr_q;   // next free slot
    logic                   push;
    logic                   pop;

    assign push = upd.update && (upd.br_type == BR_CALL);
    assign pop  = upd.update && (upd.br_type == BR_RET);

    assign top_o = stack_q[top_q]; // read combinationally

    // pointers, empty stack has top one below write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_q <= BPU_RAS_LEN'(BPU_RAS_DEPTH - 1);
            wr_q  <= '0;
        end else if (push) begin
            top_q <= wr_q;
            wr_q  <= wr_q + BPU_RAS_LEN'(1);
        end else if (pop) begin
            wr_q  <= top_q;
            top_q <= top_q - BPU_RAS_LEN'(1);
        end
    end

    // storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            stack_q[wr_q] <= upd.pc + 32'd4; // return lands after the call
        end
    end

endmodule

`default_nettype wire

//--- hw/bpu_top.sv
// bpu top, plain ports only; all tables trained by the first backend correction marked for update
`default_nettype none

module bpu_top (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire                                          flush_i,
    input  wire  [31:0]                                  redir_addr_i,
    input  wire  [1:0]                                   corr_update_i,
    input  wire  [1:0][31:0]                             corr_pc_i,
    input  wire  [1:0][31:0]                             corr_target_i,
    input  wire  bpu_pkg::br_type_e [1:0]                corr_br_type_i,
    input  wire  [1:0]                                   corr_taken_i,
    input  wire  [1:0]                                   corr_type_miss_i,
    input  wire  [1:0]                                   corr_target_miss_i,
    input  wire  [1:0][bpu_pkg::BPU_HISTORY_LEN-1:0]     corr_history_i,
    input  wire  [1:0][1:0]                              corr_scnt_i,
    input  wire                                          fetch_ready_i,
    output logic                                         fetch_valid_o,
    output logic [31:0]                                  fetch_pc_o,
    output logic [1:0]                                   fetch_mask_o,
    output logic [1:0]                                   pred_taken_o,
    output logic [31:0]                                  pred_next_pc_o,
    output logic [1:0][bpu_pkg::BPU_HISTORY_LEN-1:0]     pred_history_o, // returned with corrections
    output logic [1:0][1:0]                              pred_scnt_o
);
    import bpu_pkg::*;

    logic [31:0]      lookup_pc;
    logic [1:0]       btb_hit;
    br_type_e [1:0]   btb_type;
    logic [1:0][31:0] btb_target;
    logic [1:0]       dir_taken;
    logic [31:0]      ras_top;

    bpu_update_if upd_if (); // selected correction

    bpu_pc_ctrl i_pc_ctrl (
        .clk, .rst_n, .flush_i, .redir_addr_i,
        .corr_update_i, .corr_pc_i, .corr_target_i, .corr_br_type_i, .corr_taken_i,
        .corr_type_miss_i, .corr_target_miss_i, .corr_history_i, .corr_scnt_i,
        .upd            (upd_if.ctrl),
        .btb_hit_i      (btb_hit),
        .btb_type_i     (btb_type),
        .btb_target_i   (btb_target),
        .dir_taken_i    (dir_taken),
        .ras_top_i      (ras_top),
        .lookup_pc_o    (lookup_pc),
        .fetch_ready_i, .fetch_valid_o, .fetch_pc_o, .fetch_mask_o,
        .pred_taken_o, .pred_next_pc_o
    );

    bpu_btb i_btb (
        .clk, .rst_n,
        .lookup_pc_i (lookup_pc),
        .upd         (upd_if.tbl),
        .hit_o       (btb_hit),
        .br_type_o   (btb_type),
        .target_o    (btb_target)
    );

    bpu_dir i_dir (
        .clk, .rst_n,
        .lookup_pc_i (lookup_pc),
        .upd         (upd_if.tbl),
        .taken_o     (dir_taken),
        .history_o   (pred_history_o),
        .scnt_o      (pred_scnt_o)
    );

    bpu_ras i_ras (
        .clk, .rst_n,
        .upd   (upd_if.tbl),
        .top_o (ras_top)
    );

endmodule

`default_nettype wire

//--- hw/bpu_update_if.sv
// one selected backend correction per cycle; a pulse, taken by every table at the next edge
`default_nettype none

interface bpu_update_if;
    import bpu_pkg::*;

    logic                       update;      // correction present this cycle
    logic [31:0]                pc;          // pc of the corrected instruction
    logic [31:0]                target_pc;   // resolved target
    br_type_e                   br_type;
    logic                       taken;       // resolved direction
    logic                       type_miss;   // btb had no or wrong entry
    logic                       target_miss;
    logic [BPU_HISTORY_LEN-1:0] history;     // history seen at prediction
    logic [1:0]                 scnt;        // counter seen at prediction

    modport ctrl (output update, pc, target_pc, br_type, taken,
                  type_miss, target_miss, history, scnt);

    modport tbl (input update, pc, target_pc, br_type, taken,
                 type_miss, target_miss, history, scnt);

endinterface

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the bpu testbench with verilator, pass only if the log has the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_bpu_top \
    -f all.f -Mdir obj_dir -o sim_bpu \
    && ./obj_dir/sim_bpu > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qF '*** PASSED ***' sim.log && echo "bpu simulation passed" \
    || { echo "bpu simulation failed"; exit 1; }
